/* soc_bus_pkg.sv */
//****************************************
// Bus request and response types and the memory map of the memory subsystem.
// Import this package in every module that uses the word bus.
//****************************************
package soc_bus_pkg;

	localparam int RAM_WORDS   = 256;              // On-chip SRAM depth in 32-bit words.
	localparam int RAM_INDEX_W = 8;                // Word index width, log2 of RAM_WORDS.
	localparam logic [31:0] CFG_ADDR = 32'h0200_0000; // Flash configuration register.

	// Master request. A zero strobe field marks a read.
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
	} mem_req_t;

	// Target response. Ready completes the transfer and rdata is valid with it.
	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
	} mem_rsp_t;

	// The external I/O port carries the same shapes as the internal bus.
	typedef mem_req_t io_req_t;
	typedef mem_rsp_t io_rsp_t;

	// Decoded target of a request.
	typedef enum logic [1:0] {
		REGION_RAM,   // addr[31:24] == 0x00.
		REGION_FLASH, // addr[31:24] == 0x01.
		REGION_CFG,   // Exactly CFG_ADDR.
		REGION_IO     // Everything else.
	} mem_region_e;

endpackage

/* spi_flash_pkg.sv */
//****************************************
// Types for the single-bit SPI flash read path and its configuration.
//****************************************
package spi_flash_pkg;

	localparam logic [7:0] CFG_DIV_RESET = 8'd1; // Clock divider after reset.

	// Outgoing flash pins. Miso comes back as a plain input.
	typedef struct packed {
		logic csb;  // Chip select, active low.
		logic sclk; // Serial clock, idles low in mode 0.
		logic mosi; // Serial data towards the flash.
	} flash_pins_t;

	// Configuration register. The reserved bits always read as zero.
	typedef struct packed {
		logic [23:0] reserved;
		logic [7:0]  clk_div; // Half SPI period is clk_div+1 clk cycles.
	} flash_cfg_t;

	// Flash opcodes. Only the plain read is issued by the controller.
	typedef enum logic [7:0] {
		CMD_READ      = 8'h03,
		CMD_FAST_READ = 8'h0B
	} flash_cmd_e;

	// Read controller states.
	typedef enum logic [2:0] {ST_IDLE, ST_CMD, ST_ADDR, ST_DATA, ST_DONE} reader_state_e;

endpackage

/* soc_bus_decode.sv */
//****************************************
// Address decoder with response multiplexer and flash configuration register.
// Sits between the bus master and the SRAM, flash reader and I/O port.
//****************************************
`timescale 1ns/1ps

module soc_bus_decode
	import soc_bus_pkg::*;
	import spi_flash_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  mem_req_t   req,
	output mem_rsp_t   rsp,
	output mem_req_t   ram_req,
	input  mem_rsp_t   ram_rsp,
	output mem_req_t   flash_req,
	input  mem_rsp_t   flash_rsp,
	output io_req_t    io_req,
	input  io_rsp_t    io_rsp,
	output flash_cfg_t flash_cfg
);

	mem_region_e region;
	logic [7:0]  cfg_div;  // The only stored field of the configuration register.

	// The exact configuration address wins over the I/O range.
	always_comb begin
		if (req.addr == CFG_ADDR)         region = REGION_CFG;
		else if (req.addr[31:24] == 8'h00) region = REGION_RAM;
		else if (req.addr[31:24] == 8'h01) region = REGION_FLASH;
		else                               region = REGION_IO;
	end

	// Each target sees the full request, but valid only for its own region.
	always_comb begin
		ram_req         = req;
		ram_req.valid   = req.valid && (region == REGION_RAM);
		flash_req       = req;
		flash_req.valid = req.valid && (region == REGION_FLASH);
		io_req          = req;
		io_req.valid    = req.valid && (region == REGION_IO);
	end

	// Only byte lane 0 holds stored bits, so only wstrb[0] matters.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg_div <= CFG_DIV_RESET;
		end else if (req.valid && region == REGION_CFG && req.wstrb[0]) begin
			cfg_div <= req.wdata[7:0]; // Applied at the edge that completes the write.
		end
	end

	assign flash_cfg = '{reserved: 24'h0, clk_div: cfg_div};

	// The response of the selected target goes straight back to the master.
	always_comb begin
		rsp = '0;
		unique case (region)
			REGION_RAM:   rsp = ram_rsp;
			REGION_FLASH: rsp = flash_rsp;
			REGION_CFG:   rsp = '{ready: req.valid, rdata: flash_cfg}; // Answered at once.
			REGION_IO:    rsp = io_rsp;                                // Latency set outside.
		endcase
	end

endmodule

/* soc_sram.sv */
//****************************************
// On-chip word RAM with byte write strobes and a one-cycle response.
//****************************************
`timescale 1ns/1ps

module soc_sram
	import soc_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t req,
	output mem_rsp_t rsp
);

	logic [31:0]            mem [RAM_WORDS];
	logic [RAM_INDEX_W-1:0] index;      // Word index, above the byte offset.
	logic                   rsp_ready;
	logic [31:0]            rsp_rdata;
	logic                   accept;     // A new request is taken at this edge.

	assign index  = req.addr[RAM_INDEX_W+1:2];
	assign accept = req.valid && !rsp_ready; // Do not serve the held request twice.

	// Ready follows a new request by one cycle and then drops for a cycle.
	always_ff @(posedge clk) begin
		if (!rst_n) rsp_ready <= 1'b0;
		else        rsp_ready <= accept;
	end

	// Read the old word and merge the enabled bytes in the same edge.
	always_ff @(posedge clk) begin
		if (accept) begin
			rsp_rdata <= mem[index];
			for (int b = 0; b < 4; b++) begin
				if (req.wstrb[b]) mem[index][8*b +: 8] <= req.wdata[8*b +: 8];
			end
		end
	end

	assign rsp = '{ready: rsp_ready, rdata: rsp_rdata};

endmodule

/* spi_flash_reader.sv */
//****************************************
// Single-bit SPI read controller. Each bus read sends command 0x03 and a
// 24-bit address, then shifts in one little-endian 32-bit word.
//****************************************
`timescale 1ns/1ps

module spi_flash_reader
	import soc_bus_pkg::*;
	import spi_flash_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  mem_req_t    req,
	output mem_rsp_t    rsp,
	input  flash_cfg_t  cfg,
	output flash_pins_t pins,
	input  logic        miso
);

	reader_state_e state;
	logic [7:0]    div_cnt;   // Prescaler, one sclk toggle each clk_div+1 cycles.
	logic [4:0]    bit_cnt;   // Bits completed in the current phase.
	logic          csb;
	logic          sclk;
	logic [31:0]   shift_out; // Command then address, sent MSB first.
	logic [31:0]   shift_in;  // First received byte ends up in [31:24].
	logic          active;    // Chip selected and sclk running.
	logic          tick;
	logic          rise;
	logic          fall;
	logic          start;

	assign active = (state == ST_CMD) || (state == ST_ADDR) || (state == ST_DATA);
	assign tick   = active && (div_cnt == cfg.clk_div);
	assign rise   = tick && !sclk; // Flash samples mosi, we sample miso.
	assign fall   = tick && sclk;  // Both sides move to the next bit.
	assign start  = (state == ST_IDLE) && req.valid && (req.wstrb == 4'b0000);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			csb     <= 1'b1;
			sclk    <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			if (tick) begin
				div_cnt <= '0;
				sclk    <= ~sclk;
			end else if (active) begin
				div_cnt <= div_cnt + 8'd1;
			end
			unique case (state)
				ST_IDLE: begin
					if (start) begin
						state   <= ST_CMD;
						csb     <= 1'b0;
						div_cnt <= cfg.clk_div; // First rising edge on the next cycle.
						bit_cnt <= '0;
					end else if (req.valid) begin
						state <= ST_DONE;       // Flash writes are dropped.
					end
				end
				ST_CMD: begin
					if (fall) begin
						bit_cnt <= (bit_cnt == 5'd7) ? 5'd0 : bit_cnt + 5'd1;
						if (bit_cnt == 5'd7) state <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					if (fall) begin
						bit_cnt <= (bit_cnt == 5'd23) ? 5'd0 : bit_cnt + 5'd1;
						if (bit_cnt == 5'd23) state <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (fall) begin
						bit_cnt <= bit_cnt + 5'd1;       // Wraps to zero after bit 31.
						if (bit_cnt == 5'd31) state <= ST_DONE;
					end
				end
				ST_DONE: begin
					csb   <= 1'b1;  // Deselect one cycle after the last falling edge.
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Shift registers carry payload only and follow the same edge strobes.
	always_ff @(posedge clk) begin
		if (start) begin
			shift_out <= {CMD_READ, req.addr[23:0]};
		end else if (fall && (state == ST_CMD || state == ST_ADDR)) begin
			shift_out <= {shift_out[30:0], 1'b0};
		end
		if (rise && state == ST_DATA) begin
			shift_in <= {shift_in[30:0], miso};
		end
	end

	// The first byte received is the lowest addressed byte of the word.
	assign rsp = '{
		ready: (state == ST_DONE),
		rdata: {shift_in[7:0], shift_in[15:8], shift_in[23:16], shift_in[31:24]}
	};

	// Mosi is held low while the flash is deselected.
	assign pins = '{csb: csb, sclk: sclk, mosi: !csb && shift_out[31]};

endmodule

/* soc_mem_subsys.sv */
//****************************************
// Memory subsystem top. Connects the bus decoder, the SRAM and the
// SPI flash reader to the master bus, the I/O port and the flash pins.
//****************************************
`timescale 1ns/1ps

module soc_mem_subsys
	import soc_bus_pkg::*;
	import spi_flash_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  mem_req_t    req,        // From the bus master.
	output mem_rsp_t    rsp,
	output io_req_t     io_req,     // Pass-through I/O port.
	input  io_rsp_t     io_rsp,
	output flash_pins_t flash_pins,
	input  logic        flash_miso
);

	mem_req_t   ram_req;
	mem_rsp_t   ram_rsp;
	mem_req_t   flash_req;
	mem_rsp_t   flash_rsp;
	flash_cfg_t flash_cfg;  // Divider setting from the configuration register.

	soc_bus_decode u_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.rsp       (rsp),
		.ram_req   (ram_req),
		.ram_rsp   (ram_rsp),
		.flash_req (flash_req),
		.flash_rsp (flash_rsp),
		.io_req    (io_req),
		.io_rsp    (io_rsp),
		.flash_cfg (flash_cfg)
	);

	soc_sram u_sram (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (ram_req),
		.rsp   (ram_rsp)
	);

	spi_flash_reader u_flash (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (flash_req),
		.rsp   (flash_rsp),
		.cfg   (flash_cfg),
		.pins  (flash_pins),
		.miso  (flash_miso)
	);

endmodule

/* tb_clock_gen.sv */
//****************************************
// Testbench clock and reset. 4 ns clock, reset held low for 8 cycles.
//****************************************
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		forever #2 clk = ~clk; // Half period of 2 ns.
	end

	initial begin
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1; // Released away from the sampling edge.
	end

endmodule

/* tb_spi_flash_model.sv */
//****************************************
// Behavioural serial NOR flash. Answers command 0x03 in SPI mode 0 with
// a byte pattern computed from the byte address.
//****************************************
`timescale 1ns/1ps

module tb_spi_flash_model
	import spi_flash_pkg::*;
(
	input  flash_pins_t pins,
	output logic        miso
);

	logic [31:0] in_bits;  // Command and address, MSB first.
	int          rise_cnt; // Rising sclk edges since chip select.
	int          d;        // Index of the data bit being sent.
	logic [7:0]  cur;

	// Byte stored at a flash byte address.
	function automatic logic [7:0] pattern_byte(input logic [23:0] a);
		return (a[7:0] ^ 8'hA5) + a[15:8];
	endfunction

	initial begin
		miso     = 1'b0;
		in_bits  = '0;
		rise_cnt = 0;
	end

	always @(posedge pins.csb) rise_cnt = 0; // A new command starts after deselect.

	// The flash takes mosi on rising sclk.
	always @(posedge pins.sclk) begin
		if (!pins.csb) begin
			if (rise_cnt < 32) in_bits = {in_bits[30:0], pins.mosi};
			rise_cnt++;
		end
	end

	// Data goes out on falling sclk, bytes in address order, each MSB first.
	always @(negedge pins.sclk) begin
		if (!pins.csb && rise_cnt >= 32 && in_bits[31:24] == CMD_READ) begin
			d    = rise_cnt - 32;
			cur  = pattern_byte(in_bits[23:0] + 24'(d >> 3));
			miso = cur[7 - (d & 7)];
		end
	end

endmodule

/* soc_mem_subsys_properties.sv */
//****************************************
// Concurrent checks on the master bus, I/O port and flash pins.
// Bound into every instance of the memory subsystem top.
//****************************************
`timescale 1ns/1ps

module soc_mem_subsys_properties
	import soc_bus_pkg::*;
	import spi_flash_pkg::*;
(
	input logic        clk,
	input logic        rst_n,
	input mem_req_t    req,
	input mem_rsp_t    rsp,
	input io_req_t     io_req,
	input flash_pins_t flash_pins
);

	// A waiting request keeps all of its fields.
	req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		req.valid && !rsp.ready |=> $stable(req)) else $error("Request changed while waiting");

	ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		rsp.ready |-> req.valid) else $error("Ready raised without a request");

	// Sclk only moves while the flash is selected.
	sclk_in_transfer: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(flash_pins.sclk) |-> !flash_pins.csb) else $error("Sclk toggled with csb high");

	no_io_for_cfg: assert property (@(posedge clk) disable iff (!rst_n)
		io_req.valid |-> io_req.addr != CFG_ADDR) else $error("I/O port saw the config address");

endmodule

bind soc_mem_subsys soc_mem_subsys_properties u_props (.*);

/* tb_soc_mem_subsys.sv */
//****************************************
// Testbench top for the memory subsystem. Drives the master bus, answers
// the I/O port, and checks every read against a shadow model.
//****************************************
`timescale 1ns/1ps

module tb_soc_mem_subsys
	import soc_bus_pkg::*;
	import spi_flash_pkg::*;
();

	localparam int     N_TRANS    = 90;                  // Planned bus transfers, rounded up.
	localparam int     MAX_DIV    = 4;                   // Largest clk_div the tests use.
	localparam int     WORST      = 64 * 2 * (MAX_DIV + 1) + 8; // Flash read in clk cycles.
	localparam longint TIMEOUT_NS = (longint'(N_TRANS) * WORST + 200) * 4;

	logic        clk;
	logic        rst_n;
	logic        flash_miso;
	mem_req_t    req;
	mem_rsp_t    rsp;
	io_req_t     io_req;
	io_rsp_t     io_rsp;
	flash_pins_t flash_pins;

	int          seed = 81911;
	int          errors = 0;
	logic [31:0] shadow_ram [RAM_WORDS];
	logic [7:0]  shadow_div = CFG_DIV_RESET;
	logic [31:0] addr_q[$]; // Completed reads waiting for the check.
	logic [31:0] got_q[$];
	logic [31:0] exp_q[$];

	tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

	soc_mem_subsys UUT (
		.clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp), .io_req(io_req),
		.io_rsp(io_rsp), .flash_pins(flash_pins), .flash_miso(flash_miso)
	);

	tb_spi_flash_model u_flash_model (.pins(flash_pins), .miso(flash_miso));

	function automatic logic [7:0] flash_byte(input logic [23:0] a);
		return (a[7:0] ^ 8'hA5) + a[15:8];
	endfunction

	// Expected read data from the memory map.
	function automatic logic [31:0] ref_rdata(input logic [31:0] addr);
		logic [23:0] a;
		a = addr[23:0];
		if (addr == CFG_ADDR) return {24'h0, shadow_div};
		if (addr[31:24] == 8'h00) return shadow_ram[addr[RAM_INDEX_W+1:2]];
		if (addr[31:24] == 8'h01) return {flash_byte(a + 3), flash_byte(a + 2),
			flash_byte(a + 1), flash_byte(a)}; // First byte lands in the low lane.
		return ~addr; // The I/O responder answers with the inverted address.
	endfunction

	// One bus transfer. Ready is sampled 1 ns after the falling edge.
	task automatic transfer(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb, output logic [31:0] rdata, output int cycles);
		@(negedge clk);
		req    = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
		cycles = 0;
		#1;
		while (!rsp.ready) begin
			@(negedge clk);
			#1;
			cycles++;
		end
		rdata = rsp.rdata;
		@(negedge clk);
		req.valid = 1'b0; // The transfer completed at the rising edge in between.
	endtask

	task automatic do_read(input logic [31:0] addr);
		logic [31:0] rdata;
		int          cycles;
		transfer(addr, 32'h0, 4'h0, rdata, cycles);
		addr_q.push_back(addr);
		got_q.push_back(rdata);
		exp_q.push_back(ref_rdata(addr));
		if (addr[31:24] == 8'h00)
			assert (cycles == 1) else begin
				$display("SRAM answered after %0d cycles instead of one at %0t", cycles, $time);
				errors++;
			end
	endtask

	task automatic do_write(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb);
		logic [31:0] rdata;
		int          cycles;
		transfer(addr, wdata, wstrb, rdata, cycles);
		// SRAM and flash writes both finish one cycle after valid.
		if (addr[31:24] == 8'h00 || addr[31:24] == 8'h01)
			assert (cycles == 1) else begin
				$display("Write to %h answered after %0d cycles instead of one at %0t",
					addr, cycles, $time);
				errors++;
			end
		if (addr == CFG_ADDR) begin
			if (wstrb[0]) shadow_div = wdata[7:0]; // Only the divider byte is stored.
		end else if (addr[31:24] == 8'h00) begin
			for (int b = 0; b < 4; b++)
				if (wstrb[b]) shadow_ram[addr[RAM_INDEX_W+1:2]][8*b +: 8] = wdata[8*b +: 8];
		end
	endtask

	// I/O responder. Fields are checked at the rising edge and ready rises on a falling one.
	initial begin
		int   delay;
		io_rsp = '0;
		forever begin
			@(posedge clk);
			if (rst_n && io_req.valid) begin
				assert (req.addr[31:24] > 8'h01 && req.addr != CFG_ADDR) else begin
					$display("I/O port selected for address %h at %0t", req.addr, $time);
					errors++;
				end
				assert (io_req.addr == req.addr && io_req.wdata == req.wdata
					&& io_req.wstrb == req.wstrb) else begin
					$display("MISMATCH at %0t: I/O fields %h/%h/%h", $time,
						io_req.addr, io_req.wdata, io_req.wstrb);
					errors++;
				end
				delay = 2 + $unsigned($random(seed)) % 4;
				repeat (delay - 1) @(posedge clk);
				@(negedge clk);
				io_rsp = '{ready: 1'b1, rdata: ~io_req.addr};
				@(negedge clk);
				io_rsp = '0;
			end
		end
	end

	// Compare process for completed reads.
	initial begin
		logic [31:0] a;
		logic [31:0] got;
		logic [31:0] exp;
		forever begin
			@(negedge clk);
			while (got_q.size() > 0) begin
				a   = addr_q.pop_front();
				got = got_q.pop_front();
				exp = exp_q.pop_front();
				assert (got === exp) else begin
					$display("MISMATCH at %0t: read %h gave %h, expected %h", $time, a, got, exp);
					errors++;
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before the tests completed");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [31:0] a;
		logic [3:0]  s;
		req = '0;
		wait (rst_n);
		@(negedge clk);
		#1;
		assert (!rsp.ready && !io_req.valid && flash_pins.csb && !flash_pins.sclk) else begin
			$display("Outputs were not idle after reset");
			errors++;
		end
		do_read(CFG_ADDR); // Divider reset value.
		for (int i = 0; i < 16; i++) do_write(32'(i) << 2, $random(seed), 4'hF);
		for (int i = 0; i < 16; i++) begin
			s = $random(seed);
			if (s == 4'h0) s = 4'h1;
			do_write(($unsigned($random(seed)) % 16) << 2, $random(seed), s);
		end
		for (int i = 0; i < 16; i++) do_read(32'(i) << 2);
		for (int i = 0; i < 6; i++) do_read({8'h01, 24'($random(seed)) & 24'hFF_FFFC});
		do_write(CFG_ADDR, 32'hFFFF_FF04, 4'hF); // Reserved bits must read back as zero.
		do_read(CFG_ADDR);
		for (int i = 0; i < 4; i++) do_read({8'h01, 24'($random(seed)) & 24'hFF_FFFC});
		do_write(32'h0100_0040, 32'hDEAD_BEEF, 4'hF); // Flash writes are dropped.
		do_read(32'h0100_0040);
		do_write(CFG_ADDR, 32'h0000_0002, 4'h1);
		do_write(CFG_ADDR, 32'h0000_0700, 4'hE); // No strobe on the divider lane.
		do_read(CFG_ADDR);
		for (int i = 0; i < 2; i++) do_read({8'h01, 24'($random(seed)) & 24'hFF_FFFC});
		for (int i = 0; i < 8; i++) begin
			a = {4'h4, 28'($random(seed))};
			if (i % 2) do_write(a, $random(seed), 4'($random(seed)) | 4'h1);
			else       do_read(a);
		end
		do_read(CFG_ADDR + 32'h4); // Next to the config register, still I/O.
		while (got_q.size() > 0) @(negedge clk);
		repeat (2) @(negedge clk);
		$display("Run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* list.f */
soc_bus_pkg.sv
spi_flash_pkg.sv
soc_bus_decode.sv
soc_sram.sv
spi_flash_reader.sv
soc_mem_subsys.sv
tb_clock_gen.sv
tb_spi_flash_model.sv
soc_mem_subsys_properties.sv
tb_soc_mem_subsys.sv

/* Bender.yml */
package:
  name: soc_mem_subsys

sources:
  - soc_bus_pkg.sv
  - spi_flash_pkg.sv
  - soc_bus_decode.sv
  - soc_sram.sv
  - spi_flash_reader.sv
  - soc_mem_subsys.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_spi_flash_model.sv
      - soc_mem_subsys_properties.sv
      - tb_soc_mem_subsys.sv
